//--- filelist.f
verilog/enc_pkg.sv
verilog/ctu_scan.sv
verilog/stage_pipe.sv
verilog/stage_sync.sv
verilog/frame_ctrl.sv
verilog/enc_sched_top.sv
verif/tb_enc_sched.sv

//--- Bender.yml
package:
  name: enc_sched

sources:
  # RTL, package first
  - verilog/enc_pkg.sv
  - verilog/ctu_scan.sv
  - verilog/stage_pipe.sv
  - verilog/stage_sync.sv
  - verilog/frame_ctrl.sv
  - verilog/enc_sched_top.sv

  # testbench
  - target: test
    files:
      - verif/tb_enc_sched.sv

//--- verif/tb_enc_sched.sv
// testbench for the CTU scheduler with random stage engines and a raster-order model
`timescale 1ns/1ps
`default_nettype none

module tb_enc_sched import enc_pkg::*; ();

  localparam int N_FRAMES  = 6;
  localparam int MAX_CTUS  = 60;
  localparam int MAX_LAT   = 12;
  // worst case every stage waits the longest latency for every CTU
  localparam int TIMEOUT_CYCLES = N_FRAMES * MAX_CTUS * STAGE_NUM * (MAX_LAT + 1) + 2000;

  logic                       clk;
  logic                       rst_i;
  logic                       sys_start_i;
  pic_size_t                  sys_size_i;
  logic [STAGE_NUM-1:0]       stage_done_i;
  stage_cmd_t [STAGE_NUM-1:0] stage_cmd_o;
  logic                       sys_done_o;
  logic                       busy_o;

  integer         seed;
  int             error_cnt;
  int             cycle_cnt;
  int             sys_done_cnt;
  int             n_ctu;
  logic           frame_active;
  ctu_pos_t       exp_list[$];
  int             start_cnt [STAGE_NUM];
  int             done_cnt [STAGE_NUM];
  int             lat_cnt [STAGE_NUM];
  logic [STAGE_NUM-1:0] pend;
  logic [STAGE_NUM-1:0] start_vec;

  enc_sched_top enc_sched_top_inst (
    .clk          ( clk          ),
    .rst_i        ( rst_i        ),
    .sys_start_i  ( sys_start_i  ),
    .sys_size_i   ( sys_size_i   ),
    .stage_done_i ( stage_done_i ),
    .stage_cmd_o  ( stage_cmd_o  ),
    .sys_done_o   ( sys_done_o   ),
    .busy_o       ( busy_o       )
  );

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  // --------------------------------------------------------------------------
  // error reporting and compare tasks
  // --------------------------------------------------------------------------

  task automatic report_error(input string msg);
    error_cnt++;
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_cmd(input string name, input ctu_pos_t got, input ctu_pos_t exp);
    if (got !== exp) begin
      report_error($sformatf("Mismatch %s: got 0x%0h (x 0x%0h y 0x%0h) expected 0x%0h",
                             name, got, got.x, got.y, exp));
    end
  endtask

  task automatic check_done(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    if (got !== exp) begin
      report_error($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // only the start bit is defined before the first step
  task automatic check_idle(input string name, input stage_cmd_t got, input stage_cmd_t exp);
    if (got.start !== exp.start) begin
      report_error($sformatf("Mismatch %s.start: got 0x%0h expected 0x%0h", name, got.start,
                             exp.start));
    end
  endtask

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + int'($unsigned(r) % (hi - lo + 1));
  endfunction

  // --------------------------------------------------------------------------
  // stage engines pulse done after a drawn latency
  // --------------------------------------------------------------------------

  always @(posedge clk) begin
    #1;
    for (int k = 0; k < STAGE_NUM; k++) begin
      if (lat_cnt[k] > 0) begin
        lat_cnt[k]--;
        stage_done_i[k] = (lat_cnt[k] == 0);
      end else begin
        stage_done_i[k] = 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // monitor sampled mid-cycle
  // --------------------------------------------------------------------------

  always @(negedge clk) begin
    if (!rst_i) begin
      for (int k = 0; k < STAGE_NUM; k++) begin
        start_vec[k] = stage_cmd_o[k].start;
      end
      if ((|start_vec) && (|pend)) begin
        report_error("a stage was started while another stage was still pending");
      end
      // every start falls inside a running frame
      if (|start_vec) begin
        check_done("busy_o", 16'(busy_o), 16'h1);
      end
      for (int k = 0; k < STAGE_NUM; k++) begin
        if (start_vec[k]) begin
          if (start_cnt[k] >= exp_list.size()) begin
            report_error($sformatf("stage %0d started with no CTU left in the frame", k));
          end
          check_cmd($sformatf("stage_cmd_o[%0d].pos", k), stage_cmd_o[k].pos,
                    exp_list[start_cnt[k]]);
          if (k > 0 && done_cnt[k-1] <= start_cnt[k]) begin
            report_error($sformatf("stage %0d started a CTU before stage %0d finished it",
                                   k, k - 1));
          end
          start_cnt[k]++;
          pend[k]    = 1'b1;
          lat_cnt[k] = rand_range(1, MAX_LAT);
        end
      end
      for (int k = 0; k < STAGE_NUM; k++) begin
        if (stage_done_i[k]) begin
          pend[k] = 1'b0;
          done_cnt[k]++;
        end
      end
      if (sys_done_o) begin
        if (!frame_active) begin
          report_error("sys_done_o pulsed with no frame in progress");
        end
        // frame is closed only once ec has finished the last CTU
        check_done("stage EC done count", 16'(done_cnt[STAGE_EC]), 16'(n_ctu));
        check_done("pending stages at sys_done_o", 16'(pend), 16'h0);
        check_done("busy_o", 16'(busy_o), 16'h0);
        frame_active = 1'b0;
        sys_done_cnt++;
      end
    end
  end

  // cycle limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      report_error($sformatf("Timeout after %0d cycles, frame never finished", cycle_cnt));
    end
  end

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    int w;
    int h;
    int grid_w;
    int grid_h;
    stage_cmd_t idle_cmd;
    ctu_pos_t exp_pos;

    seed         = 32'hc8b942f3;
    error_cnt    = 0;
    cycle_cnt    = 0;
    sys_done_cnt = 0;
    n_ctu        = 0;
    frame_active = 1'b0;
    pend         = '0;
    idle_cmd     = '0;
    rst_i        = 1'b1;
    sys_start_i  = 1'b0;
    sys_size_i   = '0;
    stage_done_i = '0;
    for (int k = 0; k < STAGE_NUM; k++) begin
      start_cnt[k] = 0;
      done_cnt[k]  = 0;
      lat_cnt[k]   = 0;
    end

    repeat (8) @(posedge clk);
    #1;
    rst_i = 1'b0;

    // quiet outputs before the first frame
    repeat (4) begin
      @(negedge clk);
      for (int k = 0; k < STAGE_NUM; k++) begin
        check_idle($sformatf("stage_cmd_o[%0d]", k), stage_cmd_o[k], idle_cmd);
      end
      check_done("sys_done_o", 16'(sys_done_o), 16'h0);
      check_done("busy_o", 16'(busy_o), 16'h0);
    end

    for (int f = 0; f < N_FRAMES; f++) begin
      w      = rand_range(1, 640);
      h      = rand_range(1, 384);
      grid_w = (w + LCU_SIZE - 1) / LCU_SIZE;
      grid_h = (h + LCU_SIZE - 1) / LCU_SIZE;
      n_ctu  = grid_w * grid_h;
      exp_list.delete();
      for (int y = 0; y < grid_h; y++) begin
        for (int x = 0; x < grid_w; x++) begin
          exp_pos.x = CTU_X_WIDTH'(x);
          exp_pos.y = CTU_Y_WIDTH'(y);
          exp_list.push_back(exp_pos);
        end
      end
      for (int k = 0; k < STAGE_NUM; k++) begin
        start_cnt[k] = 0;
        done_cnt[k]  = 0;
      end

      @(posedge clk);
      #1;
      sys_start_i       = 1'b1;
      sys_size_i.width  = PIC_WIDTH'(w);
      sys_size_i.height = PIC_WIDTH'(h);
      frame_active      = 1'b1;
      @(posedge clk);
      #1;
      sys_start_i = 1'b0;

      // a second start during the frame must be dropped
      repeat (rand_range(2, 20)) @(posedge clk);
      #1;
      if (busy_o) begin
        sys_start_i       = 1'b1;
        sys_size_i.width  = PIC_WIDTH'(rand_range(1, 640));
        sys_size_i.height = PIC_WIDTH'(rand_range(1, 384));
        @(posedge clk);
        #1;
        sys_start_i = 1'b0;
      end

      while (sys_done_cnt == f) begin
        @(posedge clk);
      end
      #1;
      for (int k = 0; k < STAGE_NUM; k++) begin
        check_done($sformatf("stage %0d start count", k), 16'(start_cnt[k]), 16'(n_ctu));
        check_done($sformatf("stage %0d done count", k), 16'(done_cnt[k]), 16'(n_ctu));
      end
      check_done("sys_done_o pulses", 16'(sys_done_cnt), 16'(f + 1));
      repeat (rand_range(1, 5)) @(posedge clk);
    end

    // no late pulse after the last frame
    repeat (20) @(posedge clk);
    check_done("sys_done_o pulses", 16'(sys_done_cnt), 16'(N_FRAMES));

    if (error_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/enc_sched_top.sv
// CTU scheduler top, scan, stage pipe, stage sync and frame control
`timescale 1ns/1ps
`default_nettype none

module enc_sched_top import enc_pkg::*; (
  input  wire                         clk,
  input  wire                         rst_i,
  input  wire                         sys_start_i,
  input  wire pic_size_t              sys_size_i,
  input  wire [STAGE_NUM-1:0]         stage_done_i,
  output stage_cmd_t [STAGE_NUM-1:0]  stage_cmd_o,
  output logic                        sys_done_o,
  output logic                        busy_o
);

  logic                 frame_start;
  logic                 run;
  logic                 step;
  ctu_pos_t             scan_pos;
  logic                 scan_valid;
  logic                 scan_exhausted;
  logic [STAGE_NUM-1:0] occupied;

  // --------------------------------------------------------------------------
  // frame control
  // --------------------------------------------------------------------------

  frame_ctrl frame_ctrl_inst (
    .clk           ( clk            ),
    .rst_i         ( rst_i          ),
    .sys_start_i   ( sys_start_i    ),
    .step_i        ( step           ),
    .exhausted_i   ( scan_exhausted ),
    .occupied_i    ( occupied       ),
    .frame_start_o ( frame_start    ),
    .run_o         ( run            ),
    .sys_done_o    ( sys_done_o     )
  );

  assign busy_o = run;

  // --------------------------------------------------------------------------
  // CTU source
  // --------------------------------------------------------------------------

  ctu_scan ctu_scan_inst (
    .clk           ( clk            ),
    .rst_i         ( rst_i          ),
    .frame_start_i ( frame_start    ),
    .size_i        ( sys_size_i     ),
    .step_i        ( step           ),
    .pos_o         ( scan_pos       ),
    .valid_o       ( scan_valid     ),
    .exhausted_o   ( scan_exhausted )
  );

  // --------------------------------------------------------------------------
  // stage pipe and handshake
  // --------------------------------------------------------------------------

  stage_pipe stage_pipe_inst (
    .clk           ( clk            ),
    .rst_i         ( rst_i          ),
    .step_i        ( step           ),
    .in_pos_i      ( scan_pos       ),
    .in_valid_i    ( scan_valid     ),
    .cmd_o         ( stage_cmd_o    ),
    .occupied_o    ( occupied       )
  );

  stage_sync stage_sync_inst (
    .clk           ( clk            ),
    .rst_i         ( rst_i          ),
    .run_i         ( run            ),
    .scan_valid_i  ( scan_valid     ),
    .occupied_i    ( occupied       ),
    .done_i        ( stage_done_i   ),
    .step_o        ( step           )
  );

endmodule

`default_nettype wire

//--- verilog/frame_ctrl.sv
// idle/run frame FSM with frame start and frame done pulses
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl import enc_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   sys_start_i,
  input  wire                   step_i,
  input  wire                   exhausted_i,
  input  wire [STAGE_NUM-1:0]   occupied_i,
  output logic                  frame_start_o,
  output logic                  run_o,
  output logic                  sys_done_o
);

  // run_q low is the idle state
  logic run_q;
  logic frame_start_q;
  logic sys_done_q;
  logic start_accept;
  logic frame_end;

  // starts during a frame are dropped
  assign start_accept = sys_start_i & ~run_q;

  // final step moves the lone ec CTU out
  assign frame_end = run_q & step_i & exhausted_i & ~(|occupied_i[STAGE_EC-1:0]);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      run_q         <= 1'b0;
      frame_start_q <= 1'b0;
      sys_done_q    <= 1'b0;
    end else begin
      frame_start_q <= start_accept;
      sys_done_q    <= frame_end;
      if (start_accept) begin
        run_q <= 1'b1;
      end else if (frame_end) begin
        run_q <= 1'b0;
      end
    end
  end

  assign frame_start_o = frame_start_q;
  assign run_o         = run_q;
  assign sys_done_o    = sys_done_q;

  // done only closes a frame that was running
  done_after_run_a: assert property (@(posedge clk) disable iff (rst_i)
    sys_done_o |-> $past(run_q) && !run_q);

endmodule

`default_nettype wire

//--- verilog/stage_sync.sv
// pending bit per stage and the pipeline step decision
`timescale 1ns/1ps
`default_nettype none

module stage_sync import enc_pkg::*; (
  input  wire                   clk,
  input  wire                   rst_i,
  input  wire                   run_i,
  input  wire                   scan_valid_i,
  input  wire [STAGE_NUM-1:0]   occupied_i,
  input  wire [STAGE_NUM-1:0]   done_i,
  output logic                  step_o
);

  logic [STAGE_NUM-1:0] pending_q;
  logic [STAGE_NUM-1:0] occ_next;
  logic [STAGE_NUM-1:0] pending_set;
  logic                 any_work;
  logic                 all_idle;

  // stages that hold a CTU after the coming step
  assign occ_next = {occupied_i[STAGE_REC:STAGE_IME], scan_valid_i};

  // either something left in the pipe or the scan still has CTUs
  assign any_work = (|occupied_i) | scan_valid_i;
  assign all_idle = ~(|pending_q);

  assign step_o = run_i & all_idle & any_work;

  assign pending_set = step_o ? occ_next : '0;

  // --------------------------------------------------------------------------
  // pending tracking
  // --------------------------------------------------------------------------

  // a new start outranks a done in the same cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= (pending_q & ~done_i) | pending_set;
    end
  end

  // engines only answer stages that were started
  done_pending_a: assert property (@(posedge clk) disable iff (rst_i)
    (done_i & ~pending_q) == '0);

endmodule

`default_nettype wire

//--- verilog/stage_pipe.sv
// CTU position shift register over ime, fme, rec and ec with per-stage start pulses
`timescale 1ns/1ps
`default_nettype none

module stage_pipe import enc_pkg::*; (
  input  wire                         clk,
  input  wire                         rst_i,
  input  wire                         step_i,
  input  wire ctu_pos_t               in_pos_i,
  input  wire                         in_valid_i,
  output stage_cmd_t [STAGE_NUM-1:0]  cmd_o,
  output logic [STAGE_NUM-1:0]        occupied_o
);

  ctu_pos_t [STAGE_NUM-1:0] pos_q;
  logic [STAGE_NUM-1:0]     occ_q;
  logic [STAGE_NUM-1:0]     occ_next;
  logic [STAGE_NUM-1:0]     start_q;

  // occupancy once the step has shifted everything toward ec
  assign occ_next = {occ_q[STAGE_NUM-2:0], in_valid_i};

  // --------------------------------------------------------------------------
  // valid bits and start pulses
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst_i) begin
      occ_q   <= '0;
      start_q <= '0;
    end else begin
      start_q <= step_i ? occ_next : '0;
      if (step_i) begin
        occ_q <= occ_next;
      end
    end
  end

  // --------------------------------------------------------------------------
  // positions follow their valid bits
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (step_i) begin
      pos_q[STAGE_IME] <= in_pos_i;
      for (int k = STAGE_FME; k <= STAGE_EC; k++) begin
        pos_q[k] <= pos_q[k-1];
      end
    end
  end

  always_comb begin
    for (int k = 0; k < STAGE_NUM; k++) begin
      cmd_o[k].start = start_q[k];
      cmd_o[k].pos   = pos_q[k];
    end
  end

  assign occupied_o = occ_q;

  // starts only right after a step, and only where a CTU sits
  start_occupied_a: assert property (@(posedge clk) disable iff (rst_i)
    (|start_q) |-> $past(step_i) && ((start_q & ~occupied_o) == '0));

endmodule

`default_nettype wire

//--- verilog/ctu_scan.sv
// CTU grid from the picture size and raster-order CTU position counter
`timescale 1ns/1ps
`default_nettype none

module ctu_scan import enc_pkg::*; (
  input  wire              clk,
  input  wire              rst_i,
  input  wire              frame_start_i,
  input  wire pic_size_t   size_i,
  input  wire              step_i,
  output ctu_pos_t         pos_o,
  output logic             valid_o,
  output logic             exhausted_o
);

  pic_size_t              size_q;
  logic [PIC_WIDTH:0]     grid_w;
  logic [PIC_WIDTH:0]     grid_h;
  logic [CTU_X_WIDTH-1:0] last_x_q;
  logic [CTU_Y_WIDTH-1:0] last_y_q;
  ctu_pos_t               pos_q;
  logic                   valid_q;
  logic                   exhausted_q;
  logic                   row_end;
  logic                   col_end;

  // size arrives with sys_start_i, one cycle ahead of frame_start
  always_ff @(posedge clk) begin
    size_q <= size_i;
  end

  // CTUs per axis, partial CTUs at the border count as whole ones
  assign grid_w = ({1'b0, size_q.width} + (PIC_WIDTH+1)'(LCU_SIZE - 1)) /
                  (PIC_WIDTH+1)'(LCU_SIZE);
  assign grid_h = ({1'b0, size_q.height} + (PIC_WIDTH+1)'(LCU_SIZE - 1)) /
                  (PIC_WIDTH+1)'(LCU_SIZE);

  always_ff @(posedge clk) begin
    if (frame_start_i) begin
      last_x_q <= CTU_X_WIDTH'(grid_w - 1'b1);
      last_y_q <= CTU_Y_WIDTH'(grid_h - 1'b1);
    end
  end

  assign row_end = (pos_q.x == last_x_q);
  assign col_end = (pos_q.y == last_y_q);

  // raster walk, one CTU per step
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pos_q       <= '0;
      valid_q     <= 1'b0;
      exhausted_q <= 1'b0;
    end else if (frame_start_i) begin
      pos_q       <= '0;
      valid_q     <= 1'b1;
      exhausted_q <= 1'b0;
    end else if (step_i && valid_q) begin
      if (row_end) begin
        pos_q.x <= '0;
        if (col_end) begin
          valid_q     <= 1'b0;
          exhausted_q <= 1'b1;
        end else begin
          pos_q.y <= pos_q.y + 1'b1;
        end
      end else begin
        pos_q.x <= pos_q.x + 1'b1;
      end
    end
  end

  assign pos_o       = pos_q;
  assign valid_o     = valid_q;
  assign exhausted_o = exhausted_q;

  // offered position stays inside the latched grid
  pos_in_grid_a: assert property (@(posedge clk) disable iff (rst_i)
    valid_o |-> (pos_o.x <= last_x_q) && (pos_o.y <= last_y_q));

endmodule

`default_nettype wire

//--- verilog/enc_pkg.sv
// widths, stage indices and struct types shared by the CTU scheduler
`default_nettype none

package enc_pkg;

  // --------------------------------------------------------------------------
  // picture and CTU geometry
  // --------------------------------------------------------------------------

  // pixels per picture dimension
  localparam int PIC_WIDTH   = 13;

  // CTU edge in pixels
  localparam int LCU_SIZE    = 64;

  // CTU index widths, 128 CTUs per axis at most
  localparam int CTU_X_WIDTH = 7;
  localparam int CTU_Y_WIDTH = 7;

  // --------------------------------------------------------------------------
  // encoder stages
  // --------------------------------------------------------------------------

  localparam int STAGE_NUM   = 4;

  // position in the pipe, ime first and ec last
  localparam int STAGE_IME   = 0;
  localparam int STAGE_FME   = 1;
  localparam int STAGE_REC   = 2;
  localparam int STAGE_EC    = 3;

  // --------------------------------------------------------------------------
  // bundled signals
  // --------------------------------------------------------------------------

  // picture size in pixels
  typedef struct packed {
    logic [PIC_WIDTH-1:0] width;
    logic [PIC_WIDTH-1:0] height;
  } pic_size_t;

  // CTU column and row
  typedef struct packed {
    logic [CTU_X_WIDTH-1:0] x;
    logic [CTU_Y_WIDTH-1:0] y;
  } ctu_pos_t;

  // one-cycle start for a stage, with the CTU it works on
  typedef struct packed {
    logic     start;
    ctu_pos_t pos;
  } stage_cmd_t;

endpackage

`default_nettype wire
